// File: tests/mips_cases.txt
# case <name> <expected writebacks>, then prog <word count> <hex instruction words>
# then regs <count> and that many pairs of <register index> <expected hex value>
case alu_rtype 11
prog 12 2001000C 2002FFFB 00221820 00222022 00222824 00223025 00223826 0041402A
   0022482A 00015100 00025F02 FC000000
regs 11 1 0000000C 2 FFFFFFFB 3 00000007 4 00000011 5 00000008 6 FFFFFFFF
   7 FFFFFFF7 8 00000001 9 00000000 10 000000C0 11 0000000F
case immediates 7
prog 8 20018001 3022F0F0 34038765 3C04ABCD 34841234 2085FFFF 3C068000 FC000000
regs 6 1 FFFF8001 2 00008000 3 00008765 4 ABCD1234 5 ABCD1233 6 80000000
case forwarding 7
prog 8 20010001 00211020 00411820 00622020 00832822 00A40820 20260064 FC000000
regs 6 1 00000007 2 00000002 3 00000003 4 00000005 5 00000002 6 0000006B
case zero_register 4
prog 5 20000037 00000820 3400FFFF 20020009 FC000000
regs 3 0 00000000 1 00000000 2 00000009
case halt_stops_fetch 2
prog 6 20010003 20020004 FC000000 20010063 2003004D FC000000
regs 3 1 00000003 2 00000004 3 00000000
case reset_clears 1
prog 2 20040010 FC000000
regs 5 1 00000000 2 00000000 3 00000000 4 00000010 11 00000000

// File: sim.f
+incdir+hw
hw/mips_pkg.sv
hw/instruction_fetch.sv
hw/instruction_decode.sv
hw/execution.sv
hw/mips_core.sv
tests/mips_checker.sv
tests/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tb_mips_core \
   -Mdir obj_dir || exit 1
out="$(./obj_dir/Vtb_mips_core)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'TEST RESULT: PASS' && exit 0 || exit 1

// File: tests/tb_mips_core.sv
`default_nettype none

`include "mips_cfg.svh"

module tb_mips_core;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int    RESET_CYCLES = 2;
   localparam int    HALT_TIMEOUT = 200;
   localparam string CASES_FILE   = "tests/mips_cases.txt";

   logic                         clock;
   logic                         reset;
   mips_pkg::imem_wr_t           imem_wr;
   logic                         run;
   logic [`MIPS_NB_REG_ADDR-1:0] dbg_reg_addr;
   logic [`MIPS_NB_REG-1:0]      dbg_reg_data;
   mips_pkg::wb_t                wb;
   logic                         halted;
   logic                         check_en;
   logic [`MIPS_NB_REG-1:0]      check_value;
   int                           error_count;
   int                           cases_run;
   logic [`MIPS_NB_REG-1:0]      prog_words [`MIPS_IMEM_DEPTH];
   int                           reg_index  [`MIPS_REGFILE_DEPTH];
   logic [`MIPS_NB_REG-1:0]      reg_expect [`MIPS_REGFILE_DEPTH];

   mips_core DUT (
      .i_clock        (clock),
      .reset          (reset),
      .i_imem_wr      (imem_wr),
      .i_run          (run),
      .i_dbg_reg_addr (dbg_reg_addr),
      .o_dbg_reg_data (dbg_reg_data),
      .o_wb           (wb),
      .o_halted       (halted)
   );

   mips_checker u_checker (
      .i_clock        (clock),
      .reset          (reset),
      .i_wb           (wb),
      .i_dbg_reg_addr (dbg_reg_addr),
      .i_dbg_reg_data (dbg_reg_data),
      .i_check_en     (check_en),
      .i_check_value  (check_value),
      .o_error_count  (error_count)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   task automatic apply_reset();
      @(posedge clock);
      reset <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clock);
      reset <= 1'b0;
   endtask

   task automatic load_program(input int words);
      for (int i = 0; i < words; i++) begin
         @(posedge clock);
         imem_wr <= '{strobe: 1'b1, addr: i[`MIPS_NB_IMEM_ADDR-1:0], data: prog_words[i]};
      end
      @(posedge clock);
      imem_wr <= '0;
   endtask

   task automatic pulse_run();
      @(posedge clock);
      run <= 1'b1;
      @(posedge clock);
      run <= 1'b0;
   endtask

   task automatic wait_for_halt(output bit seen);
      seen = 1'b0;
      for (int cycle = 0; cycle < HALT_TIMEOUT && !seen; cycle++) begin
         @(negedge clock);
         seen = halted;
      end
   endtask

   // One register per cycle for the checker at the falling edge
   task automatic read_registers(input int count);
      for (int i = 0; i < count; i++) begin
         @(posedge clock);
         dbg_reg_addr <= reg_index[i][`MIPS_NB_REG_ADDR-1:0];
         check_value  <= reg_expect[i];
         check_en     <= 1'b1;
      end
      @(posedge clock);
      check_en <= 1'b0;
   endtask

   task automatic run_case(input string name, input int words, input int wb_expected,
                           input int reg_count);
      bit seen;
      apply_reset();
      u_checker.begin_case(name);
      load_program(words);
      pulse_run();
      wait_for_halt(seen);
      if (seen) begin
         read_registers(reg_count);
      end
      else begin
         u_checker.note_timeout(HALT_TIMEOUT);
      end
      u_checker.end_case(wb_expected);
      cases_run++;
   endtask

   initial begin
      int    fd;
      int    code;
      int    words;
      int    wb_expected;
      int    reg_count;
      bit    setup_error;
      string tok;
      string name;
      string line;

      reset        = 1'b1;
      imem_wr      = '0;
      run          = 1'b0;
      dbg_reg_addr = '0;
      check_en     = 1'b0;
      check_value  = '0;
      cases_run    = 0;
      words        = 0;
      wb_expected  = 0;
      setup_error  = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock);
      reset <= 1'b0;

      fd = $fopen(CASES_FILE, "r");
      if (fd == 0) begin
         $display("could not open the cases file %s", CASES_FILE);
         setup_error = 1'b1;
      end
      while (!setup_error && $fscanf(fd, "%s", tok) == 1) begin
         if (tok == "#") begin
            code = $fgets(line, fd);
         end
         else if (tok == "case") begin
            code = $fscanf(fd, "%s %d", name, wb_expected);
            if (code != 2) begin
               $display("bad case line in the cases file");
               setup_error = 1'b1;
            end
         end
         else if (tok == "prog") begin
            code = $fscanf(fd, "%d", words);
            if (code != 1 || words < 1 || words > `MIPS_IMEM_DEPTH) begin
               setup_error = 1'b1;
            end
            for (int i = 0; i < words && !setup_error; i++) begin
               code = $fscanf(fd, "%h", prog_words[i]);
               if (code != 1) begin
                  setup_error = 1'b1;
               end
            end
            if (setup_error) begin
               $display("bad program entry in the cases file");
            end
         end
         else if (tok == "regs") begin
            code = $fscanf(fd, "%d", reg_count);
            if (code != 1 || reg_count < 0 || reg_count > `MIPS_REGFILE_DEPTH) begin
               setup_error = 1'b1;
            end
            for (int i = 0; i < reg_count && !setup_error; i++) begin
               code = $fscanf(fd, "%d %h", reg_index[i], reg_expect[i]);
               if (code != 2) begin
                  setup_error = 1'b1;
               end
            end
            if (setup_error) begin
               $display("bad register entry in the cases file");
            end
            else begin
               run_case(name, words, wb_expected, reg_count);
            end
         end
         else begin
            $display("unexpected entry '%s' in the cases file", tok);
            setup_error = 1'b1;
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end

      u_checker.print_summary();
      if (error_count == 0 && !setup_error && cases_run > 0) begin
         $display("TEST RESULT: PASS");
      end
      else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/mips_checker.sv
`default_nettype none

`include "mips_cfg.svh"

module mips_checker (
   input  logic                         i_clock,
   input  logic                         reset,
   input  mips_pkg::wb_t                i_wb,
   input  logic [`MIPS_NB_REG_ADDR-1:0] i_dbg_reg_addr,
   input  logic [`MIPS_NB_REG-1:0]      i_dbg_reg_data,
   input  logic                         i_check_en,
   input  logic [`MIPS_NB_REG-1:0]      i_check_value,
   output int                           o_error_count
);
   timeunit 1ns;
   timeprecision 1ps;

   int    wb_total       = 0;
   int    check_total    = 0;
   int    mismatch_total = 0;
   int    event_errors   = 0;
   int    cases_done     = 0;
   int    wb_base        = 0;
   int    error_base     = 0;
   string case_name      = "";

   assign o_error_count = mismatch_total + event_errors;

   // Registered outputs are settled at the falling edge
   always @(negedge i_clock) begin
      if (!reset && i_wb.valid) begin
         wb_total++;
      end
      if (i_check_en) begin
         check_total++;
         if (i_dbg_reg_data !== i_check_value) begin
            mismatch_total++;
            $display("mismatch at %0d ns: o_dbg_reg_data (r%0d) is %h, expected %h",
                     $time, i_dbg_reg_addr, i_dbg_reg_data, i_check_value);
         end
      end
   end

   task automatic begin_case(input string name);
      case_name  = name;
      wb_base    = wb_total;
      error_base = mismatch_total + event_errors;
   endtask

   task automatic note_timeout(input int cycles);
      $display("case %s: o_halted did not rise within %0d cycles", case_name, cycles);
      event_errors++;
   endtask

   // Writes to r0 still count as retired writebacks
   task automatic end_case(input int expected_wb);
      int seen;
      int errors;
      seen = wb_total - wb_base;
      if (seen != expected_wb) begin
         $display("mismatch at %0d ns: o_wb.valid count is %0d, expected %0d",
                  $time, seen, expected_wb);
         event_errors++;
      end
      errors = mismatch_total + event_errors - error_base;
      cases_done++;
      $display("case %s done: %0d writebacks, %0d errors", case_name, seen, errors);
   endtask

   task automatic print_summary();
      $display("cases %0d, register checks %0d, errors %0d",
               cases_done, check_total, mismatch_total + event_errors);
   endtask

endmodule

`default_nettype wire

// File: hw/mips_core.sv
`default_nettype none

`include "mips_cfg.svh"

module mips_core (
   input  logic                         i_clock,
   input  logic                         reset,
   input  mips_pkg::imem_wr_t           i_imem_wr,
   input  logic                         i_run,
   input  logic [`MIPS_NB_REG_ADDR-1:0] i_dbg_reg_addr,
   output logic [`MIPS_NB_REG-1:0]      o_dbg_reg_data,
   output mips_pkg::wb_t                o_wb,
   output logic                         o_halted
);

   mips_pkg::fetch_t fetch;
   mips_pkg::issue_t issue;

   instruction_fetch u_instruction_fetch (
      .i_clock   (i_clock),
      .reset     (reset),
      .i_imem_wr (i_imem_wr),
      .i_run     (i_run),
      .o_fetch   (fetch)
   );

   // Writeback loops back into the register file
   instruction_decode u_instruction_decode (
      .i_clock        (i_clock),
      .reset          (reset),
      .i_fetch        (fetch),
      .i_wb           (o_wb),
      .i_dbg_reg_addr (i_dbg_reg_addr),
      .o_dbg_reg_data (o_dbg_reg_data),
      .o_issue        (issue)
   );

   execution u_execution (
      .i_clock  (i_clock),
      .reset    (reset),
      .i_issue  (issue),
      .o_wb     (o_wb),
      .o_halted (o_halted)
   );

endmodule

`default_nettype wire

// File: hw/execution.sv
`default_nettype none

`include "mips_cfg.svh"

module execution (
   input  logic             i_clock,
   input  logic             reset,
   input  mips_pkg::issue_t i_issue,
   output mips_pkg::wb_t    o_wb,
   output logic             o_halted
);

   localparam int NB_HALF = `MIPS_NB_REG / 2;

   logic                    fwd_hit_a;
   logic                    fwd_hit_b;
   logic [`MIPS_NB_REG-1:0] op_a;
   logic [`MIPS_NB_REG-1:0] fwd_b;
   logic [`MIPS_NB_REG-1:0] op_b;
   logic [`MIPS_NB_REG-1:0] alu_result;

   // Forward from the previous result still in the writeback register
   assign fwd_hit_a = o_wb.valid && o_wb.rd != '0 && o_wb.rd == i_issue.rs;
   assign fwd_hit_b = o_wb.valid && o_wb.rd != '0 && o_wb.rd == i_issue.rt;

   assign op_a  = fwd_hit_a ? o_wb.data : i_issue.a;
   assign fwd_b = fwd_hit_b ? o_wb.data : i_issue.b;
   assign op_b  = i_issue.use_imm ? i_issue.imm : fwd_b;

   always_comb begin
      alu_result = '0;
      case (i_issue.alu_op)
         mips_pkg::ALU_ADD: alu_result = op_a + op_b;
         mips_pkg::ALU_SUB: alu_result = op_a - op_b;
         mips_pkg::ALU_AND: alu_result = op_a & op_b;
         mips_pkg::ALU_OR:  alu_result = op_a | op_b;
         mips_pkg::ALU_XOR: alu_result = op_a ^ op_b;
         mips_pkg::ALU_SLT: alu_result[0] = $signed(op_a) < $signed(op_b);
         // Shifts act on rt
         mips_pkg::ALU_SLL: alu_result = op_b << i_issue.shamt;
         mips_pkg::ALU_SRL: alu_result = op_b >> i_issue.shamt;
         mips_pkg::ALU_LUI: alu_result = {op_b[NB_HALF-1:0], {NB_HALF{1'b0}}};
         default:           alu_result = '0;
      endcase
   end

   always_ff @(posedge i_clock) begin
      o_wb.rd   <= i_issue.rd;
      o_wb.data <= alu_result;
      if (reset) begin
         o_wb.valid <= 1'b0;
      end
      else begin
         o_wb.valid <= i_issue.valid && i_issue.we && !i_issue.halt;
      end
   end

   // Sticky halt, dropped by the first instruction of a new run
   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_halted <= 1'b0;
      end
      else if (i_issue.valid) begin
         o_halted <= i_issue.halt;
      end
   end

endmodule

`default_nettype wire

// File: hw/instruction_decode.sv
`default_nettype none

`include "mips_cfg.svh"

module instruction_decode (
   input  logic                         i_clock,
   input  logic                         reset,
   input  mips_pkg::fetch_t             i_fetch,
   input  mips_pkg::wb_t                i_wb,
   input  logic [`MIPS_NB_REG_ADDR-1:0] i_dbg_reg_addr,
   output logic [`MIPS_NB_REG-1:0]      o_dbg_reg_data,
   output mips_pkg::issue_t             o_issue
);

   localparam int NB_IMM = 16;

   logic [`MIPS_NB_REG-1:0]      regs [`MIPS_REGFILE_DEPTH];
   logic [5:0]                   opcode_bits;
   logic [5:0]                   funct_bits;
   logic [`MIPS_NB_REG_ADDR-1:0] rs;
   logic [`MIPS_NB_REG_ADDR-1:0] rt;
   logic [`MIPS_NB_REG_ADDR-1:0] rd;
   logic [`MIPS_NB_REG_ADDR-1:0] shamt;
   logic [NB_IMM-1:0]            imm16;
   logic [`MIPS_NB_REG-1:0]      rs_data;
   logic [`MIPS_NB_REG-1:0]      rt_data;
   mips_pkg::issue_t             issue_d;

   // Instruction fields
   assign opcode_bits = i_fetch.instruction[31:26];
   assign rs          = i_fetch.instruction[25:21];
   assign rt          = i_fetch.instruction[20:16];
   assign rd          = i_fetch.instruction[15:11];
   assign shamt       = i_fetch.instruction[10:6];
   assign funct_bits  = i_fetch.instruction[5:0];
   assign imm16       = i_fetch.instruction[NB_IMM-1:0];

   // Write-through from the register being written this cycle
   function automatic logic [`MIPS_NB_REG-1:0] read_port(
      input logic [`MIPS_NB_REG_ADDR-1:0] addr,
      input logic [`MIPS_NB_REG-1:0]      stored,
      input mips_pkg::wb_t                wb
   );
      if (wb.valid && wb.rd == addr && addr != '0) begin
         return wb.data;
      end
      return stored;
   endfunction

   assign rs_data = read_port(rs, regs[rs], i_wb);
   assign rt_data = read_port(rt, regs[rt], i_wb);

   always_comb begin
      issue_d         = '0;
      issue_d.valid   = i_fetch.valid;
      issue_d.a       = rs_data;
      issue_d.b       = rt_data;
      issue_d.shamt   = shamt;
      issue_d.rs      = rs;
      issue_d.rt      = rt;
      issue_d.alu_op  = mips_pkg::ALU_ADD;
      issue_d.imm     = {{(`MIPS_NB_REG-NB_IMM){imm16[NB_IMM-1]}}, imm16};
      case (opcode_bits)
         mips_pkg::OPC_RTYPE: begin
            issue_d.rd = rd;
            issue_d.we = 1'b1;
            case (funct_bits)
               mips_pkg::FN_ADD: issue_d.alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUB: issue_d.alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND: issue_d.alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:  issue_d.alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR: issue_d.alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_SLT: issue_d.alu_op = mips_pkg::ALU_SLT;
               mips_pkg::FN_SLL: issue_d.alu_op = mips_pkg::ALU_SLL;
               mips_pkg::FN_SRL: issue_d.alu_op = mips_pkg::ALU_SRL;
               // Unknown funct retires as a bubble
               default:          issue_d.we     = 1'b0;
            endcase
         end
         mips_pkg::OPC_ADDI: begin
            issue_d.rd      = rt;
            issue_d.we      = 1'b1;
            issue_d.use_imm = 1'b1;
         end
         mips_pkg::OPC_ANDI: begin
            issue_d.rd      = rt;
            issue_d.we      = 1'b1;
            issue_d.use_imm = 1'b1;
            issue_d.alu_op  = mips_pkg::ALU_AND;
            issue_d.imm     = {{(`MIPS_NB_REG-NB_IMM){1'b0}}, imm16};
         end
         mips_pkg::OPC_ORI: begin
            issue_d.rd      = rt;
            issue_d.we      = 1'b1;
            issue_d.use_imm = 1'b1;
            issue_d.alu_op  = mips_pkg::ALU_OR;
            issue_d.imm     = {{(`MIPS_NB_REG-NB_IMM){1'b0}}, imm16};
         end
         mips_pkg::OPC_LUI: begin
            issue_d.rd      = rt;
            issue_d.we      = 1'b1;
            issue_d.use_imm = 1'b1;
            issue_d.alu_op  = mips_pkg::ALU_LUI;
            issue_d.imm     = {{(`MIPS_NB_REG-NB_IMM){1'b0}}, imm16};
         end
         mips_pkg::OPC_HALT: begin
            issue_d.halt = 1'b1;
         end
         default: begin
            issue_d.we = 1'b0;
         end
      endcase
   end

   // Register file, r0 never written
   always_ff @(posedge i_clock) begin
      if (reset) begin
         for (int i = 0; i < `MIPS_REGFILE_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end
      else if (i_wb.valid && i_wb.rd != '0) begin
         regs[i_wb.rd] <= i_wb.data;
      end
   end

   always_ff @(posedge i_clock) begin
      o_issue <= issue_d;
      if (reset) begin
         o_issue.valid <= 1'b0;
      end
   end

   assign o_dbg_reg_data = regs[i_dbg_reg_addr];

endmodule

`default_nettype wire

// File: hw/instruction_fetch.sv
`default_nettype none

`include "mips_cfg.svh"

module instruction_fetch (
   input  logic               i_clock,
   input  logic               reset,
   input  mips_pkg::imem_wr_t i_imem_wr,
   input  logic               i_run,
   output mips_pkg::fetch_t   o_fetch
);

   localparam int MSB_OPCODE = 31;
   localparam int NB_OPCODE  = 6;

   logic [`MIPS_NB_REG-1:0]       imem [`MIPS_IMEM_DEPTH];
   logic [`MIPS_NB_IMEM_ADDR-1:0] pc;
   logic                          running;
   logic                          fetch_valid;
   logic [`MIPS_NB_IMEM_ADDR-1:0] fetch_pc;
   logic [`MIPS_NB_REG-1:0]       fetch_instr;
   logic                          halt_fetched;

   // HALT already sits in the fetch register
   assign halt_fetched = fetch_valid &&
                         (fetch_instr[MSB_OPCODE-:NB_OPCODE] == mips_pkg::OPC_HALT);

   // Load port and synchronous read
   always_ff @(posedge i_clock) begin
      if (i_imem_wr.strobe) begin
         imem[i_imem_wr.addr] <= i_imem_wr.data;
      end
      fetch_instr <= imem[pc];
      fetch_pc    <= pc;
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         pc          <= '0;
         running     <= 1'b0;
         fetch_valid <= 1'b0;
      end
      else if (i_run) begin
         pc          <= '0;
         running     <= 1'b1;
         fetch_valid <= 1'b0;
      end
      else if (running && !halt_fetched) begin
         pc          <= pc + 1'b1;
         fetch_valid <= 1'b1;
      end
      else begin
         // Stop after HALT, later words stay invalid
         running     <= 1'b0;
         fetch_valid <= 1'b0;
      end
   end

   assign o_fetch = '{valid: fetch_valid, pc: fetch_pc, instruction: fetch_instr};

endmodule

`default_nettype wire

// File: hw/mips_pkg.sv
`default_nettype none

`include "mips_cfg.svh"

package mips_pkg;

   // Primary opcode field, bits 31:26
   typedef enum logic [5:0] {
      OPC_RTYPE = 6'b000000,
      OPC_ADDI  = 6'b001000,
      OPC_ANDI  = 6'b001100,
      OPC_ORI   = 6'b001101,
      OPC_LUI   = 6'b001111,
      OPC_HALT  = 6'b111111
   } opcode_e;

   // R-type function field, bits 5:0
   typedef enum logic [5:0] {
      FN_SLL = 6'b000000,
      FN_SRL = 6'b000010,
      FN_ADD = 6'b100000,
      FN_SUB = 6'b100010,
      FN_AND = 6'b100100,
      FN_OR  = 6'b100101,
      FN_XOR = 6'b100110,
      FN_SLT = 6'b101010
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SLT = 4'd5,
      ALU_SLL = 4'd6,
      ALU_SRL = 4'd7,
      ALU_LUI = 4'd8
   } alu_op_e;

   typedef struct packed {
      logic                          strobe;
      logic [`MIPS_NB_IMEM_ADDR-1:0] addr;
      logic [`MIPS_NB_REG-1:0]       data;
   } imem_wr_t;

   typedef struct packed {
      logic                          valid;
      logic [`MIPS_NB_IMEM_ADDR-1:0] pc;
      logic [`MIPS_NB_REG-1:0]       instruction;
   } fetch_t;

   typedef struct packed {
      logic                         valid;
      logic                         halt;
      alu_op_e                      alu_op;
      logic [`MIPS_NB_REG-1:0]      a;
      logic [`MIPS_NB_REG-1:0]      b;
      logic [`MIPS_NB_REG-1:0]      imm;
      logic                         use_imm;
      logic [`MIPS_NB_REG_ADDR-1:0] shamt;
      logic [`MIPS_NB_REG_ADDR-1:0] rs;
      logic [`MIPS_NB_REG_ADDR-1:0] rt;
      logic [`MIPS_NB_REG_ADDR-1:0] rd;
      logic                         we;
   } issue_t;

   // Valid here always means a register write
   typedef struct packed {
      logic                         valid;
      logic [`MIPS_NB_REG_ADDR-1:0] rd;
      logic [`MIPS_NB_REG-1:0]      data;
   } wb_t;

endpackage

`default_nettype wire

// File: hw/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath and instruction width
`define MIPS_NB_REG 32

// Register file addressing
`define MIPS_NB_REG_ADDR 5
`define MIPS_REGFILE_DEPTH 32

// Instruction memory, word addressed
`define MIPS_NB_IMEM_ADDR 6
`define MIPS_IMEM_DEPTH 64

`endif
